//--- rtl/CacheArrayIF.sv
/*
 * Shared index, write and read signals of the tag and data arrays
 */
`timescale 1ns/1ps

interface CacheArrayIF;
    ICacheTypes::index_t index;
    logic writeEnable;
    ICacheTypes::TagEntry writeEntry;
    ICacheTypes::line_t writeLine;

    // Registered outputs, valid one cycle after index
    ICacheTypes::TagEntry readEntry;
    ICacheTypes::line_t readLine;

    modport Controller (
        output index,
        output writeEnable,
        output writeEntry,
        output writeLine,
        input readEntry,
        input readLine
    );

    modport TagArray (
        input index,
        input writeEnable,
        input writeEntry,
        output readEntry
    );

    modport DataArray (
        input index,
        input writeEnable,
        input writeLine,
        output readLine
    );
endinterface

//--- rtl/FetchController.sv
/*
 * Fetch FSM with PC register, hit/miss decision and refill request
 * Drives the cache array index and write port for each state
 */
`timescale 1ns/1ps

module FetchController (
    input logic clk,
    input logic rst,
    input logic stall,
    input logic flush,
    input ICacheTypes::addr_t nextPc,
    input logic invalidate,
    input logic memReadGrant,
    input ICacheTypes::line_t memReadValue,
    input ICacheTypes::index_t sweepIndex,
    input logic sweepDone,
    input logic flushStall,
    output logic sweepStart,
    output logic memReadReq,
    output FetchTypes::lineAddr_t memAddr,
    output logic fetchValid,
    output ICacheTypes::addr_t fetchPc,
    output ICacheTypes::line_t fetchLine,
    CacheArrayIF.Controller array
);
    FetchTypes::FetchState state;
    FetchTypes::FetchState stateNext;
    ICacheTypes::addr_t pc;
    ICacheTypes::addr_t pcNext;
    logic lookup;
    logic lookupNext;
    logic pendingInvalidate;
    FetchTypes::lineAddr_t refillAddr;
    logic hit;
    logic miss;

    // Array output belongs to pc when lookup is set
    always_comb begin
        hit = array.readEntry.valid &&
            (array.readEntry.tag == pc[ICacheTypes::ADDR_WIDTH-1:ICacheTypes::TAG_LSB]);
        miss = lookup && !hit;
        fetchValid = lookup && hit;
        fetchPc = pc;
        fetchLine = array.readLine;
        memReadReq = (state == FetchTypes::State_Refill);
        memAddr = refillAddr;
    end

    // Compressed code keeps bit 1 set and steps by 2
    always_comb begin
        if (flush) begin
            pcNext = nextPc;
        end
        else if (fetchValid && !stall) begin
            pcNext = pc + (pc[1] ? ICacheTypes::addr_t'(2) : ICacheTypes::addr_t'(4));
        end
        else begin
            pcNext = pc;
        end
    end

    always_comb begin
        stateNext = state;
        unique case (state)
            FetchTypes::State_Fetch: begin
                if (pendingInvalidate) begin
                    stateNext = FetchTypes::State_Invalidate;
                end
                else if (miss && !flush) begin
                    stateNext = FetchTypes::State_Refill;
                end
            end
            FetchTypes::State_Refill: begin
                // A flush here has already moved the PC, refill still finishes
                if (memReadGrant) begin
                    stateNext = pendingInvalidate ?
                        FetchTypes::State_Invalidate : FetchTypes::State_Fetch;
                end
            end
            FetchTypes::State_Invalidate: begin
                if (sweepDone) begin
                    stateNext = FetchTypes::State_Fetch;
                end
            end
            default: begin
                stateNext = FetchTypes::State_Fetch;
            end
        endcase
        sweepStart = (stateNext == FetchTypes::State_Invalidate) &&
            (state != FetchTypes::State_Invalidate);
    end

    // Stall keeps the last lookup so the output holds
    always_comb begin
        if (flush || state != FetchTypes::State_Fetch ||
                stateNext != FetchTypes::State_Fetch) begin
            lookupNext = 1'b0;
        end
        else if (stall) begin
            lookupNext = lookup;
        end
        else begin
            lookupNext = !flushStall;
        end
    end

    always_comb begin
        array.writeLine = memReadValue;
        unique case (state)
            FetchTypes::State_Refill: begin
                array.index = refillAddr[ICacheTypes::INDEX_WIDTH-1:0];
                array.writeEnable = memReadGrant;
                array.writeEntry = '{
                    valid: 1'b1,
                    tag: refillAddr[FetchTypes::LINE_ADDR_WIDTH-1:ICacheTypes::INDEX_WIDTH]
                };
            end
            FetchTypes::State_Invalidate: begin
                // Data lines are don't-care once the valid bit is clear
                array.index = sweepIndex;
                array.writeEnable = 1'b1;
                array.writeEntry = '0;
            end
            default: begin
                array.index = pcNext[ICacheTypes::TAG_LSB-1:ICacheTypes::OFFSET_WIDTH];
                array.writeEnable = 1'b0;
                array.writeEntry = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FetchTypes::State_Fetch;
            pc <= ICacheTypes::INITIAL_PC;
            lookup <= 1'b0;
            pendingInvalidate <= 1'b0;
        end
        else begin
            state <= stateNext;
            pc <= pcNext;
            lookup <= lookupNext;
            pendingInvalidate <= invalidate || (pendingInvalidate && !sweepStart);
        end
    end

    // Line address of the missing PC, held for the whole refill
    always_ff @(posedge clk) begin
        if (state == FetchTypes::State_Fetch && stateNext == FetchTypes::State_Refill) begin
            refillAddr <= pc[ICacheTypes::ADDR_WIDTH-1:ICacheTypes::OFFSET_WIDTH];
        end
    end
endmodule

//--- rtl/FetchTimer.sv
/*
 * Invalidate sweep counter and post-flush stall countdown
 */
`timescale 1ns/1ps

module FetchTimer (
    input logic clk,
    input logic rst,
    input logic sweepStart,
    input logic flush,
    output ICacheTypes::index_t sweepIndex,
    output logic sweepDone,
    output logic flushStall
);
    logic sweeping;
    ICacheTypes::flushCount_t stallCount;

    always_comb begin
        sweepDone = sweeping &&
            (sweepIndex == ICacheTypes::index_t'(ICacheTypes::LINE_COUNT - 1));
        flushStall = (stallCount != '0);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sweeping <= 1'b0;
            sweepIndex <= '0;
            stallCount <= '0;
        end
        else begin
            // One index per cycle, last one ends the sweep
            if (sweepStart) begin
                sweeping <= 1'b1;
                sweepIndex <= '0;
            end
            else if (sweeping) begin
                sweepIndex <= sweepIndex + 1'b1;
                if (sweepDone) begin
                    sweeping <= 1'b0;
                end
            end

            if (flush) begin
                stallCount <= ICacheTypes::flushCount_t'(ICacheTypes::FLUSH_STALL_CYCLES);
            end
            else if (flushStall) begin
                stallCount <= stallCount - 1'b1;
            end
        end
    end
endmodule

//--- rtl/FetchTypes.sv
/*
 * Fetch state encoding and the memory line address type
 */
package FetchTypes;
    // Address of one cache line, byte offset dropped
    localparam int LINE_ADDR_WIDTH = ICacheTypes::ADDR_WIDTH - ICacheTypes::OFFSET_WIDTH;

    typedef enum logic [1:0] {
        State_Fetch = 2'h0,
        State_Refill = 2'h1,
        State_Invalidate = 2'h2
    } FetchState;

    typedef logic [LINE_ADDR_WIDTH-1:0] lineAddr_t;
endpackage

//--- rtl/FetchUnit.sv
/*
 * Instruction fetch front end top level
 * Controller, timer and cache arrays behind plain ports
 */
`timescale 1ns/1ps

module FetchUnit (
    input logic clk,
    input logic rst,
    input logic stall,
    input logic flush,
    input ICacheTypes::addr_t nextPc,
    input logic invalidate,
    input logic memReadGrant,
    input ICacheTypes::line_t memReadValue,
    output logic fetchValid,
    output ICacheTypes::addr_t fetchPc,
    output ICacheTypes::line_t fetchLine,
    output logic memReadReq,
    output FetchTypes::lineAddr_t memAddr
);
    logic sweepStart;
    ICacheTypes::index_t sweepIndex;
    logic sweepDone;
    logic flushStall;

    CacheArrayIF cacheArray ();

    FetchController controller (
        .clk,
        .rst,
        .stall,
        .flush,
        .nextPc,
        .invalidate,
        .memReadGrant,
        .memReadValue,
        .sweepIndex,
        .sweepDone,
        .flushStall,
        .sweepStart,
        .memReadReq,
        .memAddr,
        .fetchValid,
        .fetchPc,
        .fetchLine,
        .array(cacheArray.Controller)
    );

    FetchTimer timer (
        .clk,
        .rst,
        .sweepStart,
        .flush,
        .sweepIndex,
        .sweepDone,
        .flushStall
    );

    ICacheTagArray tagArray (
        .clk,
        .rst,
        .array(cacheArray.TagArray)
    );

    ICacheDataArray dataArray (
        .clk,
        .array(cacheArray.DataArray)
    );
endmodule

//--- rtl/ICacheDataArray.sv
/*
 * Line storage of the instruction cache
 */
`timescale 1ns/1ps

module ICacheDataArray (
    input logic clk,
    CacheArrayIF.DataArray array
);
    ICacheTypes::line_t lines [ICacheTypes::LINE_COUNT];

    always_ff @(posedge clk) begin
        if (array.writeEnable) begin
            lines[array.index] <= array.writeLine;
        end
    end

    // Registered read, one cycle after the index
    always_ff @(posedge clk) begin
        array.readLine <= lines[array.index];
    end
endmodule

//--- rtl/ICacheTagArray.sv
/*
 * Valid bits and tags of the direct-mapped instruction cache
 */
`timescale 1ns/1ps

module ICacheTagArray (
    input logic clk,
    input logic rst,
    CacheArrayIF.TagArray array
);
    logic validBits [ICacheTypes::LINE_COUNT];
    ICacheTypes::tag_t tags [ICacheTypes::LINE_COUNT];

    // Only the valid bits are cleared, so every line misses after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ICacheTypes::LINE_COUNT; i++) begin
                validBits[i] <= 1'b0;
            end
        end
        else if (array.writeEnable) begin
            validBits[array.index] <= array.writeEntry.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (array.writeEnable) begin
            tags[array.index] <= array.writeEntry.tag;
        end
    end

    // Read returns the entry before a same-cycle write
    always_ff @(posedge clk) begin
        array.readEntry <= '{
            valid: validBits[array.index],
            tag: tags[array.index]
        };
    end
endmodule

//--- rtl/ICacheTypes.sv
/*
 * Instruction cache geometry, address slicing and fetch constants
 * Address, index, tag and line types with the tag array entry
 */
package ICacheTypes;
    localparam int ADDR_WIDTH = 32;
    localparam int LINE_BYTES = 16;
    localparam int LINE_WIDTH = LINE_BYTES * 8;
    localparam int INDEX_WIDTH = 4;
    localparam int LINE_COUNT = 1 << INDEX_WIDTH;
    localparam int OFFSET_WIDTH = $clog2(LINE_BYTES);
    localparam int TAG_LSB = OFFSET_WIDTH + INDEX_WIDTH;
    localparam int TAG_WIDTH = ADDR_WIDTH - TAG_LSB;

    // Fetch stays quiet this long after a flush
    localparam int FLUSH_STALL_CYCLES = 2;
    localparam int FLUSH_COUNT_WIDTH = $clog2(FLUSH_STALL_CYCLES) + 1;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [INDEX_WIDTH-1:0] index_t;
    typedef logic [TAG_WIDTH-1:0] tag_t;
    typedef logic [LINE_WIDTH-1:0] line_t;
    typedef logic [FLUSH_COUNT_WIDTH-1:0] flushCount_t;

    localparam addr_t INITIAL_PC = 32'h0000_1000;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } TagEntry;
endpackage

//--- run.sh
#!/bin/sh
# Build the fetch unit testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module FetchUnitTb -o FetchUnitTb
./obj_dir/FetchUnitTb > sim.log 2>&1
cat sim.log
grep -q "Test completed successfully" sim.log

//--- tests/FetchTests.svh
/*
 * Directed fetch tests with check helpers, xorshift and expected-line rule
 */

function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// Each word is its byte address XOR 5a5a0000
function automatic ICacheTypes::line_t expectedLine(input ICacheTypes::addr_t addr);
    ICacheTypes::line_t line;
    ICacheTypes::addr_t base;
    base = {addr[31:4], 4'h0};
    for (int i = 0; i < 4; i++) begin
        line[32*i +: 32] = (base + 32'(4 * i)) ^ 32'h5a5a_0000;
    end
    return line;
endfunction

// Compressed code steps by 2
function automatic ICacheTypes::addr_t pcStep(input ICacheTypes::addr_t pc);
    return pc[1] ? pc + 32'd2 : pc + 32'd4;
endfunction

task automatic nextCycle();
    @(posedge clk);
    #1;
endtask

task automatic checkWord(input string testName, input string what,
        input logic [31:0] expected, input logic [31:0] actual);
    checkCount++;
    assert (actual === expected) else begin
        $display("** Error %s: %s expected %h actual %h", testName, what, expected, actual);
        errorCount++;
    end
endtask

task automatic checkLine(input string testName, input string what,
        input logic [127:0] expected, input logic [127:0] actual);
    checkCount++;
    assert (actual === expected) else begin
        $display("** Error %s: %s expected %h actual %h", testName, what, expected, actual);
        errorCount++;
    end
endtask

task automatic checkTrue(input string testName, input logic cond, input string problem);
    checkCount++;
    assert (cond) else begin
        $display("%s: %s", testName, problem);
        errorCount++;
    end
endtask

task automatic finishTest(input string testName, input int errorsBefore);
    if (errorCount == errorsBefore) begin
        $display("%s: ok", testName);
    end
    else begin
        $display("%s: %0d errors", testName, errorCount - errorsBefore);
    end
endtask

task automatic nextFetch(input string testName, input int budget);
    int cycles;
    cycles = 0;
    do begin
        nextCycle();
        cycles++;
    end while (!fetchValid && cycles < budget);
    checkTrue(testName, fetchValid, $sformatf("no valid fetch within %0d cycles", budget));
endtask

task automatic expectFetch(input string testName, input ICacheTypes::addr_t pc,
        input int budget);
    nextFetch(testName, budget);
    checkWord(testName, "fetchPc", pc, fetchPc);
    checkLine(testName, "fetchLine", expectedLine(pc), fetchLine);
endtask

task automatic redirect(input string testName, input ICacheTypes::addr_t target);
    flush = 1'b1;
    nextPc = target;
    nextCycle();
    flush = 1'b0;
    checkWord(testName, "fetchValid after flush", 32'd0, 32'(fetchValid));
endtask

task automatic firstMissTest();
    string name;
    int errorsBefore;
    name = "first miss";
    errorsBefore = errorCount;
    checkWord(name, "fetchValid after reset", 32'd0, 32'(fetchValid));
    checkWord(name, "memReadReq after reset", 32'd0, 32'(memReadReq));
    for (int i = 0; i < 10 && !memReadReq; i++) begin
        nextCycle();
    end
    checkTrue(name, memReadReq, "no memory request after the first miss");
    checkWord(name, "memAddr",
        32'(ICacheTypes::INITIAL_PC >> ICacheTypes::OFFSET_WIDTH), 32'(memAddr));
    expectFetch(name, ICacheTypes::INITIAL_PC, 20);
    checkWord(name, "grant count", 32'd1, 32'(grantCount));
    finishTest(name, errorsBefore);
endtask

task automatic sequentialTest();
    string name;
    int errorsBefore;
    int grantsBefore;
    name = "sequential hits";
    errorsBefore = errorCount;
    grantsBefore = grantCount;
    expectFetch(name, 32'h0000_1004, 4);
    expectFetch(name, 32'h0000_1008, 4);
    expectFetch(name, 32'h0000_100c, 4);
    checkWord(name, "grant count", 32'(grantsBefore), 32'(grantCount));
    // Bit 1 set gives a step of 2
    redirect(name, 32'h0000_1006);
    expectFetch(name, 32'h0000_1006, 8);
    expectFetch(name, 32'h0000_1008, 4);
    finishTest(name, errorsBefore);
endtask

task automatic stallTest();
    string name;
    int errorsBefore;
    int grantsBefore;
    ICacheTypes::addr_t heldPc;
    ICacheTypes::line_t heldLine;
    logic heldValid;
    name = "stall hold";
    errorsBefore = errorCount;
    grantsBefore = grantCount;
    stall = 1'b1;
    heldPc = fetchPc;
    heldLine = fetchLine;
    heldValid = fetchValid;
    repeat (5) begin
        nextCycle();
        checkWord(name, "fetchValid", 32'(heldValid), 32'(fetchValid));
        checkWord(name, "fetchPc", heldPc, fetchPc);
        checkLine(name, "fetchLine", heldLine, fetchLine);
        checkWord(name, "memReadReq", 32'd0, 32'(memReadReq));
    end
    stall = 1'b0;
    expectFetch(name, pcStep(heldPc), 4);
    checkWord(name, "grant count", 32'(grantsBefore), 32'(grantCount));
    finishTest(name, errorsBefore);
endtask

task automatic flushHitTest();
    string name;
    int errorsBefore;
    int grantsBefore;
    name = "flush to cached line";
    errorsBefore = errorCount;
    grantsBefore = grantCount;
    redirect(name, 32'h0000_1004);
    // No lookup while the flush stall runs
    repeat (ICacheTypes::FLUSH_STALL_CYCLES) begin
        nextCycle();
        checkWord(name, "fetchValid during flush stall", 32'd0, 32'(fetchValid));
    end
    // First lookup after the stall hits one cycle later
    nextCycle();
    checkWord(name, "fetchValid after flush stall", 32'd1, 32'(fetchValid));
    checkWord(name, "fetchPc", 32'h0000_1004, fetchPc);
    checkLine(name, "fetchLine", expectedLine(32'h0000_1004), fetchLine);
    checkWord(name, "grant count", 32'(grantsBefore), 32'(grantCount));
    finishTest(name, errorsBefore);
endtask

task automatic invalidateTest();
    string name;
    int errorsBefore;
    int grantsBefore;
    name = "invalidate";
    errorsBefore = errorCount;
    grantsBefore = grantCount;
    invalidate = 1'b1;
    nextCycle();
    invalidate = 1'b0;
    nextCycle();
    // Line was cached before the sweep and must refill now
    redirect(name, ICacheTypes::INITIAL_PC);
    expectFetch(name, ICacheTypes::INITIAL_PC, 60);
    checkWord(name, "grant count", 32'(grantsBefore + 1), 32'(grantCount));
    finishTest(name, errorsBefore);
endtask

task automatic randomRunTest();
    string name;
    int errorsBefore;
    int grantsBefore;
    int delivered;
    int cycles;
    ICacheTypes::addr_t base;
    ICacheTypes::addr_t expected;
    name = "random run over 20 lines";
    errorsBefore = errorCount;
    base = 32'h0002_0000;
    redirect(name, base);
    expected = base;
    grantsBefore = grantCount;
    delivered = 0;
    cycles = 0;
    while (delivered < 80 && cycles < 800) begin
        nextCycle();
        cycles++;
        stallRng = xorshift(stallRng);
        stall = (stallRng[1:0] == 2'b00);
        if (fetchValid) begin
            checkWord(name, "fetchPc", expected, fetchPc);
            checkLine(name, "fetchLine", expectedLine(expected), fetchLine);
            if (!stall) begin
                expected = pcStep(expected);
                delivered++;
            end
        end
    end
    stall = 1'b0;
    checkTrue(name, delivered == 80, "run stopped before 80 fetches");
    checkWord(name, "grant count", 32'(grantsBefore + 20), 32'(grantCount));
    // Lines 16 to 19 evicted the first lines of the run
    redirect(name, base);
    expectFetch(name, base, 60);
    checkWord(name, "grant count after alias", 32'(grantsBefore + 21), 32'(grantCount));
    finishTest(name, errorsBefore);
endtask

//--- tests/FetchUnitTb.sv
/*
 * Fetch unit testbench top with clock, reset, DUT and memory responder
 * Watchdog and result summary
 */
`timescale 1ns/1ps

module FetchUnitTb;
    localparam int CLOCK_PERIOD = 10;
    // Reset plus the cycle budgets of the six tests
    localparam int TEST_CYCLES = 4 + 60 + 60 + 40 + 40 + 100 + 900;
    localparam int WATCHDOG_CYCLES = TEST_CYCLES + TEST_CYCLES / 4;

    logic clk;
    logic rst;
    logic stall;
    logic flush;
    ICacheTypes::addr_t nextPc;
    logic invalidate;
    logic memReadGrant;
    ICacheTypes::line_t memReadValue;
    logic fetchValid;
    ICacheTypes::addr_t fetchPc;
    ICacheTypes::line_t fetchLine;
    logic memReadReq;
    FetchTypes::lineAddr_t memAddr;

    int checkCount = 0;
    int errorCount = 0;
    int grantCount = 0;
    logic [31:0] delayRng = 32'hadd9;
    logic [31:0] stallRng = 32'hadd9;

    FetchUnit i_dut (
        .clk,
        .rst,
        .stall,
        .flush,
        .nextPc,
        .invalidate,
        .memReadGrant,
        .memReadValue,
        .fetchValid,
        .fetchPc,
        .fetchLine,
        .memReadReq,
        .memAddr
    );

    `include "FetchTests.svh"

    initial begin
        clk = 1'b0;
        forever #(CLOCK_PERIOD / 2) clk = ~clk;
    end

    // Memory model, grants each request after 1 to 4 cycles
    initial begin
        int delay;
        FetchTypes::lineAddr_t addr;
        memReadGrant = 1'b0;
        memReadValue = '0;
        forever begin
            nextCycle();
            if (memReadReq) begin
                addr = memAddr;
                delayRng = xorshift(delayRng);
                delay = 1 + int'(delayRng % 4);
                repeat (delay) @(posedge clk);
                #1;
                checkWord("memory", "memAddr held", 32'(addr), 32'(memAddr));
                checkWord("memory", "memReadReq held", 32'd1, 32'(memReadReq));
                memReadGrant = 1'b1;
                memReadValue = expectedLine({addr, 4'h0});
                grantCount++;
                nextCycle();
                memReadGrant = 1'b0;
                checkWord("memory", "memReadReq after grant", 32'd0, 32'(memReadReq));
            end
        end
    end

    initial begin
        rst = 1'b1;
        stall = 1'b0;
        flush = 1'b0;
        nextPc = '0;
        invalidate = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        firstMissTest();
        sequentialTest();
        stallTest();
        flushHitTest();
        invalidateTest();
        randomRunTest();

        $display("Checks: %0d, errors: %0d, grants: %0d", checkCount, errorCount, grantCount);
        if (errorCount == 0) begin
            $display("Test completed successfully");
        end
        else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        $display("Watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end
endmodule

//--- verilog.f
+incdir+tests
rtl/ICacheTypes.sv
rtl/FetchTypes.sv
rtl/CacheArrayIF.sv
rtl/ICacheTagArray.sv
rtl/ICacheDataArray.sv
rtl/FetchTimer.sv
rtl/FetchController.sv
rtl/FetchUnit.sv
tests/FetchUnitTb.sv
